/* hdl/mips_pkg.sv */
// MIPS core shared definitions
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        word_t instr;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        alu_op_e  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    st_data;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        logic     use_imm;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_res;
        word_t    st_data;
        reg_idx_t rd;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
    } ex_mem_t;

    typedef struct packed {
        word_t    wr_data;
        reg_idx_t rd;
        logic     reg_wr;
    } mem_wb_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
// Instruction fetch stage
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          imem_wr_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_wr_addr_i,
    input  mips_pkg::word_t               imem_wr_data_i,
    output mips_pkg::if_id_t              if_id_o
);
    import mips_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc_q;
    word_t pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (!stall_i) begin
            pc_q <= pc_plus4;  // pc holds while decode waits on a load.
        end
    end

    always_ff @(posedge clk) begin
        if (imem_wr_en_i) begin
            imem[imem_wr_addr_i] <= imem_wr_data_i;
        end
    end

    assign if_id_o = '{instr: imem[pc_q[IMEM_AW+1:2]], pc_plus4: pc_plus4};

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
// Instruction decoder
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  mips_pkg::if_id_t   if_id_i,
    input  mips_pkg::word_t    rs_data_i,
    input  mips_pkg::word_t    rt_data_i,
    output mips_pkg::reg_idx_t rs_idx_o,
    output mips_pkg::reg_idx_t rt_idx_o,
    output mips_pkg::id_ex_t   id_ex_o
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [15:0] imm;
    reg_idx_t    dst;
    word_t       imm_ext;
    alu_op_e     alu_op;
    logic        wr;
    logic        mem_rd;
    logic        mem_wr;
    logic        use_imm;
    logic        zero_ext;
    logic        a_is_shamt;

    assign opcode   = if_id_i.instr[31:26];
    assign rs_idx_o = if_id_i.instr[25:21];
    assign rt_idx_o = if_id_i.instr[20:16];
    assign shamt    = if_id_i.instr[10:6];
    assign funct    = if_id_i.instr[5:0];
    assign imm      = if_id_i.instr[15:0];

    always_comb begin
        alu_op     = ALU_ADD;
        wr         = 1'b0;
        mem_rd     = 1'b0;
        mem_wr     = 1'b0;
        use_imm    = 1'b1;
        zero_ext   = 1'b0;
        a_is_shamt = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                use_imm = 1'b0;
                wr      = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op     = ALU_SLL;
                        a_is_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op     = ALU_SRL;
                        a_is_shamt = 1'b1;
                    end
                    default: wr = 1'b0;  // unknown funct retires as a no-op.
                endcase
            end
            OP_ADDIU: wr = 1'b1;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1;
                wr       = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
                wr       = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                wr     = 1'b1;
            end
            OP_LW: begin
                mem_rd = 1'b1;
                wr     = 1'b1;
            end
            OP_SW: mem_wr = 1'b1;
            default: use_imm = 1'b0;
        endcase
    end

    assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign dst     = (opcode == OP_RTYPE) ? if_id_i.instr[15:11] : rt_idx_o;

    // shifts take shamt on A, so rs is cleared to keep it out of forwarding.
    assign id_ex_o = '{
        alu_op:  alu_op,
        op_a:    a_is_shamt ? {27'd0, shamt} : rs_data_i,
        op_b:    use_imm ? imm_ext : rt_data_i,
        st_data: rt_data_i,
        rs:      a_is_shamt ? reg_idx_t'(0) : rs_idx_o,
        rt:      rt_idx_o,
        rd:      dst,
        reg_wr:  wr && (dst != '0),  // r0 writes are dropped here.
        mem_rd:  mem_rd,
        mem_wr:  mem_wr,
        use_imm: use_imm
    };

endmodule

`default_nettype wire

/* hdl/regfile.sv */
// Integer register file
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               w_en_i,
    input  mips_pkg::reg_idx_t w_idx_i,
    input  mips_pkg::word_t    w_data_i,
    input  mips_pkg::reg_idx_t r_idx_a_i,
    input  mips_pkg::reg_idx_t r_idx_b_i,
    output mips_pkg::word_t    r_data_a_o,
    output mips_pkg::word_t    r_data_b_o
);
    import mips_pkg::*;

    word_t regs [32];
    logic  wr_live;

    assign wr_live = w_en_i && (w_idx_i != '0);  // r0 stays zero.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[w_idx_i] <= w_data_i;
        end
    end

    // same-cycle write is visible to decode.
    assign r_data_a_o = (wr_live && w_idx_i == r_idx_a_i) ? w_data_i : regs[r_idx_a_i];
    assign r_data_b_o = (wr_live && w_idx_i == r_idx_b_i) ? w_data_i : regs[r_idx_b_i];

endmodule

`default_nettype wire

/* hdl/alu.sv */
// Execute stage ALU
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_e op_i,
    input  mips_pkg::word_t   a_i,
    input  mips_pkg::word_t   b_i,
    output mips_pkg::word_t   res_o
);
    import mips_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: res_o = a_i + b_i;
            ALU_SUB: res_o = a_i - b_i;
            ALU_AND: res_o = a_i & b_i;
            ALU_OR:  res_o = a_i | b_i;
            ALU_XOR: res_o = a_i ^ b_i;
            ALU_SLT: res_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: res_o = b_i << a_i[4:0];
            ALU_SRL: res_o = b_i >> a_i[4:0];
            ALU_LUI: res_o = {b_i[15:0], 16'h0000};
            default: res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/pipe_reg.sv */
// Pipeline stage register
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     en_i,
    input  logic     bubble_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= valid_i && !bubble_i;  // a bubble travels as an invalid slot.
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            data_o <= data_i;
        end
    end

    a_bubble_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        bubble_i |-> en_i);

endmodule

`default_nettype wire

/* hdl/data_mem.sv */
// Word-addressed data memory
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            wr_en_i,
    input  mips_pkg::word_t addr_i,
    input  mips_pkg::word_t wr_data_i,
    output mips_pkg::word_t rd_data_o
);
    import mips_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    word_t mem [DMEM_DEPTH];

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            mem[i] = '0;  // unwritten words read as zero.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[addr_i[DMEM_AW+1:2]] <= wr_data_i;
        end
    end

    assign rd_data_o = mem[addr_i[DMEM_AW+1:2]];

    a_wr_in_range: assert property (@(posedge clk)
        wr_en_i |-> (addr_i[31:2] < DMEM_DEPTH));

endmodule

`default_nettype wire

/* hdl/hazard_unit.sv */
// Forwarding and load-use control
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic               clk,
    input  logic               rst_n_i,
    input  mips_pkg::reg_idx_t id_rs_idx_i,
    input  mips_pkg::reg_idx_t id_rt_idx_i,
    input  mips_pkg::reg_idx_t ex_rs_idx_i,
    input  mips_pkg::reg_idx_t ex_rt_idx_i,
    input  mips_pkg::reg_idx_t ex_dst_idx_i,
    input  logic               ex_mem_rd_i,
    input  logic               ex_valid_i,
    input  mips_pkg::reg_idx_t mem_dst_idx_i,
    input  logic               mem_reg_wr_i,
    input  logic               mem_valid_i,
    input  mips_pkg::reg_idx_t wb_dst_idx_i,
    input  logic               wb_reg_wr_i,
    input  logic               wb_valid_i,
    output logic               stall_o,
    output mips_pkg::fwd_sel_e fwd_a_o,
    output mips_pkg::fwd_sel_e fwd_b_o
);
    import mips_pkg::*;

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic ex_load;

    assign mem_hit_a = mem_valid_i && mem_reg_wr_i && (mem_dst_idx_i == ex_rs_idx_i);
    assign mem_hit_b = mem_valid_i && mem_reg_wr_i && (mem_dst_idx_i == ex_rt_idx_i);
    assign wb_hit_a  = wb_valid_i && wb_reg_wr_i && (wb_dst_idx_i == ex_rs_idx_i);
    assign wb_hit_b  = wb_valid_i && wb_reg_wr_i && (wb_dst_idx_i == ex_rt_idx_i);

    // the younger result in mem wins over writeback.
    assign fwd_a_o = (ex_rs_idx_i == '0) ? FWD_NONE :
                     mem_hit_a ? FWD_MEM : wb_hit_a ? FWD_WB : FWD_NONE;
    assign fwd_b_o = (ex_rt_idx_i == '0) ? FWD_NONE :
                     mem_hit_b ? FWD_MEM : wb_hit_b ? FWD_WB : FWD_NONE;

    assign ex_load = ex_valid_i && ex_mem_rd_i && (ex_dst_idx_i != '0);
    assign stall_o = ex_load && (ex_dst_idx_i == id_rs_idx_i || ex_dst_idx_i == id_rt_idx_i);

    // a stall leaves exactly one empty slot in execute behind the load.
    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> ex_valid_i && ex_mem_rd_i ##1 !ex_valid_i);

endmodule

`default_nettype wire

/* hdl/mips_core.sv */
// Five-stage MIPS integer core
`timescale 1ns/100ps
`default_nettype none

module mips_core #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          imem_wr_en_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_wr_addr_i,
    input  mips_pkg::word_t               imem_wr_data_i,
    output logic                          retire_o,
    output logic                          wb_en_o,
    output mips_pkg::reg_idx_t            wb_rd_o,
    output mips_pkg::word_t               wb_data_o
);
    import mips_pkg::*;

    if_id_t   fetch_out;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    logic     if_id_valid;
    logic     id_ex_valid;
    logic     ex_mem_valid;
    logic     mem_wb_valid;
    logic     stall;
    logic     rf_wr_en;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    ex_a;
    word_t    ex_rt_val;
    word_t    ex_b;
    word_t    alu_res;
    word_t    dmem_rd_data;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .if_id_o        (fetch_out)
    );

    pipe_reg #(.payload_t(if_id_t)) i_if_id (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en_i     (!stall),
        .bubble_i (1'b0),
        .valid_i  (1'b1),
        .data_i   (fetch_out),
        .valid_o  (if_id_valid),
        .data_o   (if_id_q)
    );

    decode_unit i_decode_unit (
        .if_id_i   (if_id_q),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .rs_idx_o  (rs_idx),
        .rt_idx_o  (rt_idx),
        .id_ex_o   (id_ex_d)
    );

    regfile i_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .w_en_i     (rf_wr_en),
        .w_idx_i    (mem_wb_q.rd),
        .w_data_i   (mem_wb_q.wr_data),
        .r_idx_a_i  (rs_idx),
        .r_idx_b_i  (rt_idx),
        .r_data_a_o (rs_data),
        .r_data_b_o (rt_data)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en_i     (1'b1),
        .bubble_i (stall),
        .valid_i  (if_id_valid),
        .data_i   (id_ex_d),
        .valid_o  (id_ex_valid),
        .data_o   (id_ex_q)
    );

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_rs_idx_i   (rs_idx),
        .id_rt_idx_i   (rt_idx),
        .ex_rs_idx_i   (id_ex_q.rs),
        .ex_rt_idx_i   (id_ex_q.rt),
        .ex_dst_idx_i  (id_ex_q.rd),
        .ex_mem_rd_i   (id_ex_q.mem_rd),
        .ex_valid_i    (id_ex_valid),
        .mem_dst_idx_i (ex_mem_q.rd),
        .mem_reg_wr_i  (ex_mem_q.reg_wr),
        .mem_valid_i   (ex_mem_valid),
        .wb_dst_idx_i  (mem_wb_q.rd),
        .wb_reg_wr_i   (mem_wb_q.reg_wr),
        .wb_valid_i    (mem_wb_valid),
        .stall_o       (stall),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b)
    );

    // rt is forwarded for store data even when B takes the immediate.
    assign ex_a      = fwd_mux(fwd_a, id_ex_q.op_a, ex_mem_q.alu_res, mem_wb_q.wr_data);
    assign ex_rt_val = fwd_mux(fwd_b, id_ex_q.st_data, ex_mem_q.alu_res, mem_wb_q.wr_data);
    assign ex_b      = id_ex_q.use_imm ? id_ex_q.op_b : ex_rt_val;

    alu i_alu (
        .op_i  (id_ex_q.alu_op),
        .a_i   (ex_a),
        .b_i   (ex_b),
        .res_o (alu_res)
    );

    assign ex_mem_d = '{
        alu_res: alu_res,
        st_data: ex_rt_val,
        rd:      id_ex_q.rd,
        reg_wr:  id_ex_q.reg_wr,
        mem_rd:  id_ex_q.mem_rd,
        mem_wr:  id_ex_q.mem_wr
    };

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en_i     (1'b1),
        .bubble_i (1'b0),
        .valid_i  (id_ex_valid),
        .data_i   (ex_mem_d),
        .valid_o  (ex_mem_valid),
        .data_o   (ex_mem_q)
    );

    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) i_data_mem (
        .clk       (clk),
        .wr_en_i   (ex_mem_valid && ex_mem_q.mem_wr),
        .addr_i    (ex_mem_q.alu_res),
        .wr_data_i (ex_mem_q.st_data),
        .rd_data_o (dmem_rd_data)
    );

    assign mem_wb_d = '{
        wr_data: ex_mem_q.mem_rd ? dmem_rd_data : ex_mem_q.alu_res,
        rd:      ex_mem_q.rd,
        reg_wr:  ex_mem_q.reg_wr
    };

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .en_i     (1'b1),
        .bubble_i (1'b0),
        .valid_i  (ex_mem_valid),
        .data_i   (mem_wb_d),
        .valid_o  (mem_wb_valid),
        .data_o   (mem_wb_q)
    );

    assign rf_wr_en  = mem_wb_valid && mem_wb_q.reg_wr;
    assign retire_o  = mem_wb_valid;  // one pulse per instruction, in program order.
    assign wb_en_o   = rf_wr_en;
    assign wb_rd_o   = mem_wb_q.rd;
    assign wb_data_o = mem_wb_q.wr_data;

endmodule

`default_nettype wire

/* verification/mips_core_tb.sv */
// MIPS core testbench
`timescale 1ns/100ps
`default_nettype none

module mips_core_tb;
    import mips_pkg::*;

    localparam int          IMEM_DEPTH     = 256;
    localparam int          DMEM_DEPTH     = 256;
    localparam int          IMEM_AW        = $clog2(IMEM_DEPTH);
    localparam int          DMEM_AW        = $clog2(DMEM_DEPTH);
    localparam int          N_INSTR        = 200;
    localparam int          RESET_CYCLES   = 16;
    localparam int          DATA_WORDS     = 16;  // small window keeps store/load pairs dense.
    localparam int          FIRST_RETIRE   = 4;  // instruction 0 crosses four pipeline registers.
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + 2 * N_INSTR + 20;
    localparam int unsigned SEED           = 32'h3223_ffaa;

    logic               clk;
    logic               rst_n_i;
    logic               imem_wr_en_i;
    logic [IMEM_AW-1:0] imem_wr_addr_i;
    word_t              imem_wr_data_i;
    logic               retire_o;
    logic               wb_en_o;
    reg_idx_t           wb_rd_o;
    word_t              wb_data_o;

    word_t       prog [IMEM_DEPTH];
    word_t       model_regs [32];
    word_t       model_mem [DMEM_DEPTH];
    int          retired;
    int          run_cycles;
    int          cycle_cnt;
    logic        timer_on;
    int unsigned seed_state;
    bit          exp_en;
    reg_idx_t    exp_idx;
    word_t       exp_data;

    mips_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_mips_core (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .retire_o       (retire_o),
        .wb_en_o        (wb_en_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb_en(input bit exp);
        if (wb_en_o !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: wb_en_o is %b, expected %b (instr %0d)",
                               $time, wb_en_o, exp, retired));
        end
    endtask

    task automatic check_wb(input reg_idx_t idx, input word_t data);
        if (wb_rd_o !== idx) begin
            fail_run($sformatf("Mismatch at %0t ns: wb_rd_o is %0d, expected %0d (instr %0d)",
                               $time, wb_rd_o, idx, retired));
        end
        if (wb_data_o !== data) begin
            fail_run($sformatf("Mismatch at %0t ns: wb_data_o is %h, expected %h (instr %0d)",
                               $time, wb_data_o, data, retired));
        end
    endtask

    function automatic word_t random_instr();
        int unsigned kind;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [15:0] daddr;
        kind  = $urandom % 17;
        rs    = reg_idx_t'($urandom % 8);  // r0..r7 only.
        rt    = reg_idx_t'($urandom % 8);
        rd    = reg_idx_t'($urandom % 8);
        sh    = 5'($urandom);
        imm   = 16'($urandom);
        daddr = 16'(($urandom % DATA_WORDS) * 4);
        case (kind)
            0:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADDU};
            1:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_SUBU};
            2:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_AND};
            3:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_OR};
            4:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_XOR};
            5:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_SLT};
            6:       return {OP_RTYPE, 5'd0, rt, rd, sh, FN_SLL};
            7:       return {OP_RTYPE, 5'd0, rt, rd, sh, FN_SRL};
            8:       return {OP_ADDIU, rs, rt, imm};
            9:       return {OP_ANDI, rs, rt, imm};
            10:      return {OP_ORI, rs, rt, imm};
            11:      return {OP_LUI, 5'd0, rt, imm};
            12, 13:  return {OP_LW, 5'd0, rt, daddr};
            14:      return {OP_SW, 5'd0, rt, daddr};
            15:      return {6'h3f, rs, rt, rd, sh, 6'h3f};  // opcode outside the set.
            default: return {OP_RTYPE, rs, rt, rd, sh, 6'h3f};
        endcase
    endfunction

    // steps one instruction over the model state with MIPS semantics.
    function automatic void ref_step(input word_t instr, output bit en,
                                     output reg_idx_t idx, output word_t data);
        logic [5:0] op;
        logic [5:0] fn;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] sh;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        word_t      addr;
        op   = instr[31:26];
        fn   = instr[5:0];
        rs   = instr[25:21];
        rt   = instr[20:16];
        sh   = instr[10:6];
        a    = model_regs[rs];
        b    = model_regs[rt];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        addr = a + simm;
        en   = 1'b1;
        idx  = rt;
        data = '0;
        case (op)
            OP_RTYPE: begin
                idx = instr[15:11];
                case (fn)
                    FN_ADDU: data = a + b;
                    FN_SUBU: data = a - b;
                    FN_AND:  data = a & b;
                    FN_OR:   data = a | b;
                    FN_XOR:  data = a ^ b;
                    FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  data = b << sh;
                    FN_SRL:  data = b >> sh;
                    default: en = 1'b0;
                endcase
            end
            OP_ADDIU: data = a + simm;
            OP_ANDI:  data = a & zimm;
            OP_ORI:   data = a | zimm;
            OP_LUI:   data = {instr[15:0], 16'h0000};
            OP_LW:    data = model_mem[addr[DMEM_AW+1:2]];
            OP_SW: begin
                model_mem[addr[DMEM_AW+1:2]] = b;
                en = 1'b0;
            end
            default:  en = 1'b0;
        endcase
        if (idx == '0) begin
            en = 1'b0;
        end
        if (en) begin
            model_regs[idx] = data;
        end
    endfunction

    // outputs are checked on the falling edge.
    always @(negedge clk) begin
        if (!rst_n_i) begin
            if (retire_o !== 1'b0) begin
                fail_run($sformatf("Mismatch at %0t ns: retire_o high during reset", $time));
            end
            check_wb_en(1'b0);
        end else if (retired < N_INSTR) begin
            if (retired == 0 && retire_o !== (run_cycles == FIRST_RETIRE)) begin
                fail_run($sformatf("Mismatch at %0t ns: retire_o is %b in cycle %0d after reset",
                                   $time, retire_o, run_cycles));
            end
            if (retire_o) begin
                ref_step(prog[retired], exp_en, exp_idx, exp_data);
                check_wb_en(exp_en);
                if (exp_en) begin
                    check_wb(exp_idx, exp_data);
                end
                retired = retired + 1;
            end else begin
                check_wb_en(1'b0);
            end
            run_cycles = run_cycles + 1;
        end
    end

    always @(posedge clk) begin
        if (timer_on) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("Timeout: only %0d of %0d instructions retired in %0d cycles",
                                   retired, N_INSTR, TIMEOUT_CYCLES));
            end
        end
    end

    initial begin
        seed_state     = $urandom(SEED);
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        imem_wr_en_i   = 1'b0;
        imem_wr_addr_i = '0;
        imem_wr_data_i = '0;
        timer_on       = 1'b0;
        cycle_cnt      = 0;
        retired        = 0;
        run_cycles     = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = (i < N_INSTR) ? random_instr() : '0;  // zero word is sll r0 as no-op.
        end
        // the program is written while the core sits in reset
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            #1;
            imem_wr_en_i   = 1'b1;
            imem_wr_addr_i = IMEM_AW'(i);
            imem_wr_data_i = prog[i];
        end
        @(posedge clk);
        #1;
        imem_wr_en_i = 1'b0;
        timer_on     = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        wait (retired == N_INSTR);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/decode_unit.sv
hdl/regfile.sv
hdl/alu.sv
hdl/pipe_reg.sv
hdl/data_mem.sv
hdl/hazard_unit.sv
hdl/mips_core.sv
verification/mips_core_tb.sv

/* Makefile */
TOP = mips_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir
